//--- src/fnd_pkg.sv
package fnd_pkg;

    ////////////////////////////////////////////////////////////
    // widths
    ////////////////////////////////////////////////////////////

    localparam int COUNT_W     = 16;  // displayed hex count
    localparam int NIBBLE_W    = 4;   // one hex digit
    localparam int DIGIT_COUNT = 4;   // fnd digits on the board
    localparam int SEG_W       = 8;   // a b c d e f g dp, a is msb

    ////////////////////////////////////////////////////////////
    // data types
    ////////////////////////////////////////////////////////////

    typedef logic [COUNT_W-1:0]  count_t;
    typedef logic [NIBBLE_W-1:0] nibble_t;
    typedef logic [SEG_W-1:0]    seg_t;    // 0 lights the segment

    // scan state, encoded directly as the active-low common lines
    typedef enum logic [DIGIT_COUNT-1:0] {
        COM_D0 = 4'b1110,  // count[3:0]
        COM_D1 = 4'b1101,  // count[7:4]
        COM_D2 = 4'b1011,  // count[11:8]
        COM_D3 = 4'b0111   // count[15:12]
    } com_e;

    // counting direction, same sense as the down_up level
    typedef enum logic {
        DIR_UP   = 1'b0,
        DIR_DOWN = 1'b1
    } dir_e;

endpackage

//--- src/tick_divider.sv
module tick_divider #(
    parameter int DIV_BITS = 17
) (
    input  logic clk,
    input  logic reset_p,
    output logic tick
);

    logic [DIV_BITS-1:0] div_cnt;  // free-running prescaler
    logic                msb_cur;  // sampled top bit
    logic                msb_old;  // previous sample

    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // two-stage edge detector on the top prescaler bit
    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            msb_cur <= 1'b0;
            msb_old <= 1'b0;
        end else begin
            msb_cur <= div_cnt[DIV_BITS-1];
            msb_old <= msb_cur;
        end
    end

    // rising edge only, one pulse per 2**DIV_BITS clocks
    assign tick = msb_cur & ~msb_old;

    ////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////

    // tick must stay a single-cycle pulse
    a_tick_single : assert property (
        @(posedge clk) disable iff (reset_p)
        tick |=> !tick
    ) else $error("tick_divider: tick high on two cycles in a row");

endmodule

//--- src/hex_counter.sv
module hex_counter (
    input  logic           clk,
    input  logic           reset_p,
    input  logic           count_tick,
    input  logic           enable,
    input  fnd_pkg::dir_e  down_up,
    output fnd_pkg::count_t count
);

    localparam fnd_pkg::count_t STEP = fnd_pkg::count_t'(1);

    logic step_en;

    assign step_en = count_tick & enable;  // counting is gated by the enable level

    // wraps modulo 2**COUNT_W in both directions
    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            count <= '0;
        end else if (step_en) begin
            case (down_up)
                fnd_pkg::DIR_UP:   count <= count + STEP;
                fnd_pkg::DIR_DOWN: count <= count - STEP;
                default:           count <= count;  // hold on an unknown direction
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////

    // count may move only right after an enabled tick
    a_count_change : assert property (
        @(posedge clk) disable iff (reset_p)
        (count != $past(count)) |-> $past(step_en)
    ) else $error("hex_counter: count changed without an enabled tick");

endmodule

//--- src/digit_scanner.sv
module digit_scanner (
    input  logic                              clk,
    input  logic                              reset_p,
    input  logic                              scan_tick,
    input  fnd_pkg::count_t                   count,
    output logic [fnd_pkg::DIGIT_COUNT-1:0]   com,
    output fnd_pkg::nibble_t                  digit_value
);

    localparam int NW = fnd_pkg::NIBBLE_W;

    fnd_pkg::com_e com_state;

    ////////////////////////////////////////////////////////////
    // common line ring
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            com_state <= fnd_pkg::COM_D0;
        end else if (scan_tick) begin
            case (com_state)
                fnd_pkg::COM_D0: com_state <= fnd_pkg::COM_D1;
                fnd_pkg::COM_D1: com_state <= fnd_pkg::COM_D2;
                fnd_pkg::COM_D2: com_state <= fnd_pkg::COM_D3;
                fnd_pkg::COM_D3: com_state <= fnd_pkg::COM_D0;
                default:         com_state <= fnd_pkg::COM_D0;  // recover from a bad state
            endcase
        end
    end

    assign com = com_state;  // state encoding is already the active-low line pattern

    ////////////////////////////////////////////////////////////
    // nibble for the lit digit
    ////////////////////////////////////////////////////////////

    // registered every clock, so seg_7 trails com by one cycle
    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            digit_value <= '0;
        end else begin
            case (com_state)
                fnd_pkg::COM_D0: digit_value <= count[0*NW +: NW];
                fnd_pkg::COM_D1: digit_value <= count[1*NW +: NW];
                fnd_pkg::COM_D2: digit_value <= count[2*NW +: NW];
                fnd_pkg::COM_D3: digit_value <= count[3*NW +: NW];
                default:         digit_value <= count[0*NW +: NW];
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////

    // exactly one digit driven at any time
    a_com_onehot : assert property (
        @(posedge clk) disable iff (reset_p)
        $onehot(~com)
    ) else $error("digit_scanner: com does not have exactly one line low");

endmodule

//--- src/seg7_decoder.sv
module seg7_decoder (
    input  fnd_pkg::nibble_t digit_value,
    output fnd_pkg::seg_t    seg_7
);

    // bit order a b c d e f g dp, 0 lights the segment, dp always off
    always_comb begin
        case (digit_value)
            4'h0:    seg_7 = 8'h03;
            4'h1:    seg_7 = 8'h9F;
            4'h2:    seg_7 = 8'h25;
            4'h3:    seg_7 = 8'h0D;
            4'h4:    seg_7 = 8'h99;
            4'h5:    seg_7 = 8'h49;
            4'h6:    seg_7 = 8'h41;
            4'h7:    seg_7 = 8'h1B;
            4'h8:    seg_7 = 8'h01;
            4'h9:    seg_7 = 8'h19;
            4'hA:    seg_7 = 8'h11;  // upper case A
            4'hB:    seg_7 = 8'hC1;  // lower case b
            4'hC:    seg_7 = 8'h63;
            4'hD:    seg_7 = 8'h85;  // lower case d
            4'hE:    seg_7 = 8'h61;
            4'hF:    seg_7 = 8'h71;
            default: seg_7 = 8'hFF;  // blank
        endcase
    end

endmodule

//--- src/fnd_counter_top.sv
module fnd_counter_top #(
    parameter int COUNT_DIV_BITS = 22,  // count rate prescaler
    parameter int SCAN_DIV_BITS  = 17   // digit scan prescaler
) (
    input  logic                            clk,
    input  logic                            reset_p,
    input  logic                            enable,
    input  fnd_pkg::dir_e                   down_up,
    output fnd_pkg::count_t                 count,
    output logic [fnd_pkg::DIGIT_COUNT-1:0] com,
    output fnd_pkg::seg_t                   seg_7
);

    logic             count_tick;
    logic             scan_tick;
    fnd_pkg::nibble_t digit_value;

    ////////////////////////////////////////////////////////////
    // rate generation
    ////////////////////////////////////////////////////////////

    tick_divider #(.DIV_BITS(COUNT_DIV_BITS)) i_count_div (
        .clk     (clk),
        .reset_p (reset_p),
        .tick    (count_tick)
    );

    tick_divider #(.DIV_BITS(SCAN_DIV_BITS)) i_scan_div (
        .clk     (clk),
        .reset_p (reset_p),
        .tick    (scan_tick)
    );

    ////////////////////////////////////////////////////////////
    // counter to display path
    ////////////////////////////////////////////////////////////

    hex_counter i_counter (
        .clk        (clk),
        .reset_p    (reset_p),
        .count_tick (count_tick),
        .enable     (enable),
        .down_up    (down_up),
        .count      (count)
    );

    digit_scanner i_scanner (
        .clk         (clk),
        .reset_p     (reset_p),
        .scan_tick   (scan_tick),
        .count       (count),
        .com         (com),
        .digit_value (digit_value)
    );

    seg7_decoder i_decoder (
        .digit_value (digit_value),
        .seg_7       (seg_7)
    );

endmodule

//--- sim/tb_fnd_counter.sv
module tb_fnd_counter;

    localparam int COUNT_DIV_BITS = 4;
    localparam int SCAN_DIV_BITS  = 3;
    localparam int STEP_TIMEOUT   = 64;                // cycles allowed for one count step
    localparam int MAX_SEGMENTS   = 64;
    localparam logic [31:0] NO_ENTRY = 32'hFFFF_FFFF;  // unused golden word

    logic                            clk;
    logic                            reset_p;
    logic                            enable;
    fnd_pkg::dir_e                   down_up;
    fnd_pkg::count_t                 count;
    logic [fnd_pkg::DIGIT_COUNT-1:0] com;
    fnd_pkg::seg_t                   seg_7;

    logic [31:0]                     golden [0:4*MAX_SEGMENTS-1];
    fnd_pkg::count_t                 prev_count;  // values seen one cycle earlier
    logic [fnd_pkg::DIGIT_COUNT-1:0] prev_com;
    int                              com_age;     // cycles since com last moved

    fnd_counter_top #(
        .COUNT_DIV_BITS (COUNT_DIV_BITS),
        .SCAN_DIV_BITS  (SCAN_DIV_BITS)
    ) i_fnd_counter_top (
        .clk     (clk),
        .reset_p (reset_p),
        .enable  (enable),
        .down_up (down_up),
        .count   (count),
        .com     (com),
        .seg_7   (seg_7)
    );

    always #20 clk = ~clk;

    ////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////

    // a..g dp with a as msb, active low
    function automatic fnd_pkg::seg_t glyph_for(input fnd_pkg::nibble_t value);
        case (value)
            4'h0: glyph_for = 8'h03;
            4'h1: glyph_for = 8'h9F;
            4'h2: glyph_for = 8'h25;
            4'h3: glyph_for = 8'h0D;
            4'h4: glyph_for = 8'h99;
            4'h5: glyph_for = 8'h49;
            4'h6: glyph_for = 8'h41;
            4'h7: glyph_for = 8'h1B;
            4'h8: glyph_for = 8'h01;
            4'h9: glyph_for = 8'h19;
            4'hA: glyph_for = 8'h11;
            4'hB: glyph_for = 8'hC1;
            4'hC: glyph_for = 8'h63;
            4'hD: glyph_for = 8'h85;
            4'hE: glyph_for = 8'h61;
            default: glyph_for = 8'h71;
        endcase
    endfunction

    function automatic fnd_pkg::nibble_t nibble_shown(input fnd_pkg::count_t value,
                                                      input logic [3:0] lines);
        case (lines)
            4'b1110: nibble_shown = value[3:0];
            4'b1101: nibble_shown = value[7:4];
            4'b1011: nibble_shown = value[11:8];
            4'b0111: nibble_shown = value[15:12];
            default: nibble_shown = 4'h0;  // caught by the one-low check
        endcase
    endfunction

    function automatic logic [3:0] ring_next(input logic [3:0] lines);
        ring_next = {lines[2:0], lines[3]};  // low line moves up one digit
    endfunction

    function automatic fnd_pkg::count_t stepped(input fnd_pkg::count_t value,
                                                input fnd_pkg::dir_e dir);
        if (dir == fnd_pkg::DIR_DOWN) begin
            stepped = value - fnd_pkg::count_t'(1);
        end else begin
            stepped = value + fnd_pkg::count_t'(1);
        end
    endfunction

    ////////////////////////////////////////////////////////////
    // error reporting
    ////////////////////////////////////////////////////////////

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic show_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] seen);
        fail_run($sformatf("CHECK FAILED at time %0t: %s expected %0h, seen %0h",
                           $time, name, expected, seen));
    endtask

    ////////////////////////////////////////////////////////////
    // per-cycle checks, sampled on the falling edge
    ////////////////////////////////////////////////////////////

    task automatic cycle_check(output logic moved);
        fnd_pkg::count_t exp_count;
        fnd_pkg::seg_t   exp_seg;
        @(negedge clk);
        moved   = 1'b0;
        exp_seg = glyph_for(nibble_shown(prev_count, prev_com));  // one cycle of latency
        assert (seg_7 == exp_seg) else show_mismatch("seg_7", 32'(exp_seg), 32'(seg_7));
        assert ($countones(~com) == 1) else
            fail_run($sformatf("com is %b at time %0t, not exactly one line low", com, $time));
        if (com != prev_com) begin
            assert (com == ring_next(prev_com)) else
                show_mismatch("com", 32'(ring_next(prev_com)), 32'(com));
            com_age = 0;
        end else begin
            com_age++;
        end
        // the ring must step once per scan tick period
        assert (com_age < (1 << SCAN_DIV_BITS)) else
            fail_run($sformatf("com stayed at %b for %0d cycles at time %0t",
                               com, com_age, $time));
        if (count != prev_count) begin
            exp_count = enable ? stepped(prev_count, down_up) : prev_count;  // hold when off
            assert (count == exp_count) else show_mismatch("count", 32'(exp_count), 32'(count));
            moved = 1'b1;
        end
        prev_count = count;
        prev_com   = com;
    endtask

    task automatic run_enabled(input int steps);
        logic moved;
        int   waited;
        for (int s = 0; s < steps; s++) begin
            moved  = 1'b0;
            waited = 0;
            while (!moved) begin
                if (waited == STEP_TIMEOUT) begin
                    fail_run($sformatf("timeout: count did not step within %0d cycles (step %0d)",
                                       STEP_TIMEOUT, s));
                end else begin
                    cycle_check(moved);
                    waited++;
                end
            end
        end
    endtask

    task automatic run_disabled(input int cycles);
        logic moved;
        for (int n = 0; n < cycles; n++) begin
            cycle_check(moved);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        logic [31:0] len_field;
        logic [31:0] exp_field;
        logic [7:0]  base;
        logic        moved;
        int          seg;
        clk        = 1'b0;
        reset_p    = 1'b1;
        enable     = 1'b0;
        down_up    = fnd_pkg::DIR_UP;
        prev_count = '0;
        prev_com   = 4'b1110;
        com_age    = 0;
        golden     = '{default: NO_ENTRY};
        $readmemh("sim/fnd_golden.txt", golden);

        repeat (2) @(negedge clk);
        reset_p    = 1'b0;
        prev_count = count;
        prev_com   = com;
        com_age    = 0;
        cycle_check(moved);
        assert (count == '0) else show_mismatch("count", 32'h0, 32'(count));
        assert (com == 4'b1110) else show_mismatch("com", 32'hE, 32'(com));
        assert (seg_7 == 8'h03) else show_mismatch("seg_7", 32'h03, 32'(seg_7));

        seg  = 0;
        base = 8'd0;
        while (seg < MAX_SEGMENTS && golden[base] != NO_ENTRY) begin
            enable    = golden[base][0];
            down_up   = golden[base + 8'd1][0] ? fnd_pkg::DIR_DOWN : fnd_pkg::DIR_UP;
            len_field = golden[base + 8'd2];
            exp_field = golden[base + 8'd3];
            if (enable) begin
                run_enabled(len_field);
            end else begin
                run_disabled(len_field);
            end
            assert (32'(count) == exp_field) else show_mismatch("count", exp_field, 32'(count));
            seg++;
            base = base + 8'd4;
        end

        if (seg == 0) begin
            fail_run("the golden file holds no segments");
        end else begin
            $display("RESULT: PASS");
            $finish;
        end
    end

endmodule

//--- sim/fnd_golden.txt
// enable down_up steps expected_count, all hex
// enabled lines wait for that many count steps, disabled lines for that many clocks
1 0 00000013 00000013
0 1 00000018 00000013
1 1 00000013 00000000
1 1 00000005 0000FFFB
// long run down so every nibble value reaches every digit
1 1 0000F000 00000FFB
0 0 00000028 00000FFB
1 0 00000022 0000101D
0 0 00000010 0000101D
1 0 00000017 00001034
1 1 00000009 0000102B
0 1 00000030 0000102B
1 1 0000002B 00001000
1 0 00000010 00001010

//--- list.f
src/fnd_pkg.sv
src/tick_divider.sv
src/hex_counter.sv
src/digit_scanner.sv
src/seg7_decoder.sv
src/fnd_counter_top.sv
sim/tb_fnd_counter.sv

//--- run.sh
#!/bin/sh
# build and run the display counter testbench from the project root
cd "$(dirname "$0")" \
    && verilator --binary --assert -f list.f --top-module tb_fnd_counter -o tb_fnd_counter \
    && ./obj_dir/tb_fnd_counter \
    || { echo "simulation did not pass"; exit 1; }
